// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

  localparam int WORD_W = 32;
  localparam int REGADDR_W = 5;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REGADDR_W-1:0] regaddr_t;

  // Boot ROM entry point in kseg1
  localparam word_t RESET_VECTOR = 32'hBFC0_0000;

  // Primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // SPECIAL function codes, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A
  } func_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC,
    MEM,
    WB,
    HALT
  } state_t;

  // Register file write destination
  typedef enum logic [1:0] {
    WB_RD,
    WB_RT,
    WB_GPR31
  } wb_sel_t;

endpackage

`default_nettype wire

// File: hw/mips_instr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mips_instr_if;

  mips_pkg::opcode_t  opcode;
  mips_pkg::func_t    funct;
  mips_pkg::regaddr_t rs;
  mips_pkg::regaddr_t rt;
  mips_pkg::regaddr_t rd;
  logic [4:0]         shamt;
  logic [15:0]        immediate;
  logic [25:0]        target;

  modport source (output opcode, funct, rs, rt, rd, shamt, immediate, target);

  modport decode (input opcode, funct);

  // The ALU needs the operation as well as the operand fields
  modport operand (input opcode, funct, rs, rt, rd, shamt, immediate, target);

endinterface

`default_nettype wire

// File: hw/mips_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mips_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall_i,
  input  logic                halt_i,
  mips_instr_if.decode        fields,
  output mips_pkg::state_t    state_o
);

  mips_pkg::state_t state_q;
  mips_pkg::state_t state_d;
  logic is_mem;
  logic is_load;
  logic skip_wb;

  // Instruction class
  assign is_load = fields.opcode == mips_pkg::OP_LW;
  assign is_mem = is_load || fields.opcode == mips_pkg::OP_SW;
  assign skip_wb = fields.opcode inside {mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_J} ||
                   (fields.opcode == mips_pkg::OP_SPECIAL && fields.funct == mips_pkg::FN_JR);

  always_comb begin
    state_d = state_q;
    if (halt_i) begin
      state_d = mips_pkg::HALT;
    end else if (!stall_i) begin
      case (state_q)
        mips_pkg::FETCH:  state_d = mips_pkg::DECODE;
        mips_pkg::DECODE: state_d = mips_pkg::EXEC;
        mips_pkg::EXEC: begin
          if (is_mem) begin
            state_d = mips_pkg::MEM;
          end else if (skip_wb) begin
            state_d = mips_pkg::FETCH;
          end else begin
            state_d = mips_pkg::WB;
          end
        end
        mips_pkg::MEM:    state_d = is_load ? mips_pkg::WB : mips_pkg::FETCH;
        mips_pkg::WB:     state_d = mips_pkg::FETCH;
        default:          state_d = mips_pkg::HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= mips_pkg::FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // HALT is absorbing until the next reset
  assert property (@(posedge clk) disable iff (reset)
    state_q == mips_pkg::HALT |=> state_q == mips_pkg::HALT);

endmodule

`default_nettype wire

// File: hw/mips_ir.sv
`timescale 1ns/1ps
`default_nettype none

module mips_ir (
  input  logic            clk,
  input  logic            reset,
  input  logic            load_i,
  input  mips_pkg::word_t instr_i,
  mips_instr_if.source    fields
);

  mips_pkg::word_t instr_q;
  mips_pkg::word_t instr;
  logic            valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      instr_q <= '0;
    end else if (load_i) begin
      instr_q <= instr_i;
    end
  end

  // Anything outside the supported subset becomes SLL r0, r0, 0
  always_comb begin
    valid = instr_q[31:26] inside {mips_pkg::OP_J, mips_pkg::OP_JAL, mips_pkg::OP_BEQ,
                                   mips_pkg::OP_BNE, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
                                   mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
                                   mips_pkg::OP_LUI, mips_pkg::OP_LW, mips_pkg::OP_SW};
    if (instr_q[31:26] == mips_pkg::OP_SPECIAL) begin
      valid = instr_q[5:0] inside {mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_JR,
                                   mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND,
                                   mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_SLT};
    end
    instr = valid ? instr_q : '0;
  end

  assign fields.opcode    = mips_pkg::opcode_t'(instr[31:26]);
  assign fields.rs        = instr[25:21];
  assign fields.rt        = instr[20:16];
  assign fields.rd        = instr[15:11];
  assign fields.shamt     = instr[10:6];
  assign fields.funct     = mips_pkg::func_t'(instr[5:0]);
  assign fields.immediate = instr[15:0];
  assign fields.target    = instr[25:0];

endmodule

`default_nettype wire

// File: hw/mips_control.sv
`timescale 1ns/1ps
`default_nettype none

module mips_control (
  input  logic               clk,
  input  logic               reset,
  input  mips_pkg::state_t   state_i,
  input  logic               waitrequest_i,
  mips_instr_if.decode       fields,
  input  logic               branch_taken_i,
  output logic               ir_load_o,
  output logic               pc_write_o,
  output logic               mem_read_o,
  output logic               mem_write_o,
  output logic               addr_sel_o,
  output logic               alu_src_imm_o,
  output logic               regfile_write_o,
  output mips_pkg::wb_sel_t  wb_sel_o,
  output logic               stall_o
);

  logic is_load;
  logic is_store;

  assign is_load  = fields.opcode == mips_pkg::OP_LW;
  assign is_store = fields.opcode == mips_pkg::OP_SW;

  always_comb begin
    ir_load_o       = 1'b0;
    pc_write_o      = 1'b0;
    mem_read_o      = 1'b0;
    mem_write_o     = 1'b0;
    addr_sel_o      = 1'b0;
    regfile_write_o = 1'b0;
    case (state_i)
      mips_pkg::FETCH: begin
        // No bus request while the core is held in reset
        mem_read_o = !reset;
        ir_load_o  = !reset && !waitrequest_i;
      end
      mips_pkg::EXEC: begin
        // Loads and stores keep the PC until the data phase is done
        pc_write_o = !(is_load || is_store);
      end
      mips_pkg::MEM: begin
        addr_sel_o  = 1'b1;
        mem_read_o  = is_load;
        mem_write_o = is_store;
        pc_write_o  = !waitrequest_i;
      end
      mips_pkg::WB: begin
        regfile_write_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Freeze everything while a strobe is outstanding
  assign stall_o = (mem_read_o || mem_write_o) && waitrequest_i;

  assign alu_src_imm_o = fields.opcode inside {mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
                                               mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                                               mips_pkg::OP_XORI, mips_pkg::OP_LUI,
                                               mips_pkg::OP_LW, mips_pkg::OP_SW};

  always_comb begin
    case (fields.opcode)
      mips_pkg::OP_SPECIAL: wb_sel_o = mips_pkg::WB_RD;
      mips_pkg::OP_JAL:     wb_sel_o = mips_pkg::WB_GPR31;
      default:              wb_sel_o = mips_pkg::WB_RT;
    endcase
  end

  assert property (@(posedge clk) disable iff (reset) !(mem_read_o && mem_write_o));

endmodule

`default_nettype wire

// File: hw/mips_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            pc_write_i,
  input  mips_pkg::word_t next_pc_i,
  output mips_pkg::word_t pc_o,
  output logic            halt_o
);

  mips_pkg::word_t pc_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= mips_pkg::RESET_VECTOR;
    end else if (pc_write_i) begin
      pc_q <= next_pc_i;
    end
  end

  assign pc_o = pc_q;

  // Look ahead so the FSM enters HALT on the edge where the PC becomes 0,
  // before any fetch from address 0 is issued
  assign halt_o = pc_write_i ? (next_pc_i == '0) : (pc_q == '0);

  // Jump and JR targets must stay word aligned
  assert property (@(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hw/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile #(
  parameter int REG_COUNT = 32
) (
  input  logic               clk,
  input  logic               reset,
  mips_instr_if.operand      regs,
  input  logic               write_i,
  input  mips_pkg::regaddr_t waddr_i,
  input  mips_pkg::word_t    wdata_i,
  output mips_pkg::word_t    rs_data_o,
  output mips_pkg::word_t    rt_data_o,
  output mips_pkg::word_t    v0_o
);

  localparam int IDX_W = $clog2(REG_COUNT);

  mips_pkg::word_t  mem_q [REG_COUNT];
  logic [IDX_W-1:0] widx;

  // Reduced builds simply drop the upper index bits
  assign widx = waddr_i[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        mem_q[i] <= '0;
      end
    end else if (write_i && widx != '0) begin
      mem_q[widx] <= wdata_i;
    end
  end

  // Entry 0 is never written, so $zero reads back as 0
  assign rs_data_o = mem_q[regs.rs[IDX_W-1:0]];
  assign rt_data_o = mem_q[regs.rt[IDX_W-1:0]];
  assign v0_o      = mem_q[2];

endmodule

`default_nettype wire

// File: hw/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
  mips_instr_if.operand   fields,
  input  mips_pkg::word_t rs_i,
  input  mips_pkg::word_t rt_i,
  input  mips_pkg::word_t pc_i,
  input  logic            use_imm_i,
  output mips_pkg::word_t result_o,
  output mips_pkg::word_t eff_addr_o,
  output mips_pkg::word_t next_pc_o,
  output logic            branch_taken_o
);

  mips_pkg::word_t sign_imm;
  mips_pkg::word_t zero_imm;
  mips_pkg::word_t op_b;
  mips_pkg::word_t pc_plus4;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  logic            logical_imm;

  assign sign_imm = {{16{fields.immediate[15]}}, fields.immediate};
  assign zero_imm = {16'h0000, fields.immediate};

  // ANDI, ORI and XORI zero-extend, everything else sign-extends
  assign logical_imm = fields.opcode inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                                             mips_pkg::OP_XORI};
  assign op_b = !use_imm_i ? rt_i : (logical_imm ? zero_imm : sign_imm);

  assign pc_plus4      = pc_i + 32'd4;
  assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], fields.target, 2'b00};
  assign eff_addr_o    = rs_i + sign_imm;

  always_comb begin
    result_o = '0;
    case (fields.opcode)
      mips_pkg::OP_SPECIAL: begin
        case (fields.funct)
          mips_pkg::FN_ADDU: result_o = rs_i + op_b;
          mips_pkg::FN_SUBU: result_o = rs_i - op_b;
          mips_pkg::FN_AND:  result_o = rs_i & op_b;
          mips_pkg::FN_OR:   result_o = rs_i | op_b;
          mips_pkg::FN_XOR:  result_o = rs_i ^ op_b;
          mips_pkg::FN_SLT:  result_o = {31'd0, $signed(rs_i) < $signed(op_b)};
          mips_pkg::FN_SLL:  result_o = rt_i << fields.shamt;
          mips_pkg::FN_SRL:  result_o = rt_i >> fields.shamt;
          default:           result_o = '0;
        endcase
      end
      mips_pkg::OP_ADDIU: result_o = rs_i + op_b;
      mips_pkg::OP_SLTI:  result_o = {31'd0, $signed(rs_i) < $signed(op_b)};
      mips_pkg::OP_ANDI:  result_o = rs_i & op_b;
      mips_pkg::OP_ORI:   result_o = rs_i | op_b;
      mips_pkg::OP_XORI:  result_o = rs_i ^ op_b;
      mips_pkg::OP_LUI:   result_o = {fields.immediate, 16'h0000};
      // Link value for JAL
      mips_pkg::OP_JAL:   result_o = pc_plus4;
      default:            result_o = '0;
    endcase
  end

  assign branch_taken_o = (fields.opcode == mips_pkg::OP_BEQ && rs_i == rt_i) ||
                          (fields.opcode == mips_pkg::OP_BNE && rs_i != rt_i);

  always_comb begin
    if (fields.opcode == mips_pkg::OP_J || fields.opcode == mips_pkg::OP_JAL) begin
      next_pc_o = jump_target;
    end else if (fields.opcode == mips_pkg::OP_SPECIAL && fields.funct == mips_pkg::FN_JR) begin
      next_pc_o = rs_i;
    end else if (branch_taken_o) begin
      next_pc_o = branch_target;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

endmodule

`default_nettype wire

// File: hw/mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus #(
  parameter int REG_COUNT = 32
) (
  input  logic        clk,
  input  logic        reset,
  output logic        active_o,
  output logic [31:0] register_v0_o,
  output logic [31:0] address_o,
  output logic        write_o,
  output logic        read_o,
  input  logic        waitrequest_i,
  output logic [31:0] writedata_o,
  input  logic [31:0] readdata_i
);

  function automatic mips_pkg::word_t swap_bytes(mips_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  mips_instr_if instr ();

  mips_pkg::state_t   state;
  mips_pkg::wb_sel_t  wb_sel;
  mips_pkg::word_t    readdata_be;
  mips_pkg::word_t    pc;
  mips_pkg::word_t    next_pc;
  mips_pkg::word_t    rs_data;
  mips_pkg::word_t    rt_data;
  mips_pkg::word_t    v0;
  mips_pkg::word_t    alu_result;
  mips_pkg::word_t    eff_addr;
  mips_pkg::word_t    alu_q;
  mips_pkg::word_t    load_q;
  mips_pkg::word_t    wdata;
  mips_pkg::regaddr_t waddr;
  logic stall, halt, ir_load, pc_write, addr_sel, alu_src_imm, regfile_write, branch_taken;

  // Memory holds big-endian words
  assign readdata_be = swap_bytes(readdata_i);

  mips_fsm i_fsm (
    .clk     (clk),
    .reset   (reset),
    .stall_i (stall),
    .halt_i  (halt),
    .fields  (instr.decode),
    .state_o (state)
  );

  mips_ir i_ir (
    .clk     (clk),
    .reset   (reset),
    .load_i  (ir_load),
    .instr_i (readdata_be),
    .fields  (instr.source)
  );

  mips_control i_control (
    .clk             (clk),
    .reset           (reset),
    .state_i         (state),
    .waitrequest_i   (waitrequest_i),
    .fields          (instr.decode),
    .branch_taken_i  (branch_taken),
    .ir_load_o       (ir_load),
    .pc_write_o      (pc_write),
    .mem_read_o      (read_o),
    .mem_write_o     (write_o),
    .addr_sel_o      (addr_sel),
    .alu_src_imm_o   (alu_src_imm),
    .regfile_write_o (regfile_write),
    .wb_sel_o        (wb_sel),
    .stall_o         (stall)
  );

  mips_pc_unit i_pc_unit (
    .clk        (clk),
    .reset      (reset),
    .pc_write_i (pc_write),
    .next_pc_i  (next_pc),
    .pc_o       (pc),
    .halt_o     (halt)
  );

  mips_regfile #(
    .REG_COUNT (REG_COUNT)
  ) i_regfile (
    .clk       (clk),
    .reset     (reset),
    .regs      (instr.operand),
    .write_i   (regfile_write),
    .waddr_i   (waddr),
    .wdata_i   (wdata),
    .rs_data_o (rs_data),
    .rt_data_o (rt_data),
    .v0_o      (v0)
  );

  mips_alu i_alu (
    .fields         (instr.operand),
    .rs_i           (rs_data),
    .rt_i           (rt_data),
    .pc_i           (pc),
    .use_imm_i      (alu_src_imm),
    .result_o       (alu_result),
    .eff_addr_o     (eff_addr),
    .next_pc_o      (next_pc),
    .branch_taken_o (branch_taken)
  );

  // The PC moves on after EXEC, so the link value is captured here
  always_ff @(posedge clk) begin
    if (state == mips_pkg::EXEC) begin
      alu_q <= alu_result;
    end
    if (state == mips_pkg::MEM && !waitrequest_i) begin
      load_q <= readdata_be;
    end
  end

  always_comb begin
    case (wb_sel)
      mips_pkg::WB_RD: begin
        waddr = instr.rd;
        wdata = alu_q;
      end
      mips_pkg::WB_GPR31: begin
        waddr = mips_pkg::regaddr_t'(31);
        wdata = alu_q;
      end
      default: begin
        waddr = instr.rt;
        wdata = (instr.opcode == mips_pkg::OP_LW) ? load_q : alu_q;
      end
    endcase
  end

  assign address_o     = addr_sel ? eff_addr : pc;
  assign writedata_o   = swap_bytes(rt_data);
  assign active_o      = state != mips_pkg::HALT;
  assign register_v0_o = v0;

endmodule

`default_nettype wire

// File: sim/mips_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mips_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        start_i,
  input  logic [31:0] prog_i [64],
  input  logic [31:0] dmem_i [256],
  input  logic        active_i,
  input  logic [31:0] register_v0_i,
  input  logic [31:0] address_i,
  input  logic        write_i,
  input  logic        read_i,
  input  logic        waitrequest_i,
  input  logic [31:0] writedata_i,
  output int          errors_o
);

  localparam logic [31:0] DATA_BASE = 32'h0000_1000;

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_v0 = 32'h0;
  logic        halted = 1'b0;
  logic        first_read = 1'b0;
  logic        held = 1'b0;
  logic        held_write = 1'b0;
  logic [31:0] held_addr = 32'h0;
  logic [31:0] held_data = 32'h0;
  int          errors = 0;

  assign errors_o = errors;

  function automatic logic [31:0] byte_swap(logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Architectural model without delay slots, as the DUT implements it
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] instr;
    logic [31:0] se;
    logic [31:0] ioff;
    logic [31:0] eoff;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    int          steps;
    regs = '{default: 32'h0};
    mem = dmem_i;
    exp_addr.delete();
    exp_data.delete();
    pc = mips_pkg::RESET_VECTOR;
    steps = 0;
    while (pc != 32'h0 && steps < 1000) begin
      ioff = pc - mips_pkg::RESET_VECTOR;
      instr = (ioff < 32'd256) ? prog_i[ioff[7:2]] : 32'h0;
      rs = instr[25:21];
      rt = instr[20:16];
      rd = instr[15:11];
      se = {{16{instr[15]}}, instr[15:0]};
      eoff = regs[rs] + se - DATA_BASE;
      npc = pc + 32'd4;
      case (instr[31:26])
        mips_pkg::OP_SPECIAL: begin
          case (instr[5:0])
            mips_pkg::FN_SLL:  regs[rd] = regs[rt] << instr[10:6];
            mips_pkg::FN_SRL:  regs[rd] = regs[rt] >> instr[10:6];
            mips_pkg::FN_JR:   npc = regs[rs];
            mips_pkg::FN_ADDU: regs[rd] = regs[rs] + regs[rt];
            mips_pkg::FN_SUBU: regs[rd] = regs[rs] - regs[rt];
            mips_pkg::FN_AND:  regs[rd] = regs[rs] & regs[rt];
            mips_pkg::FN_OR:   regs[rd] = regs[rs] | regs[rt];
            mips_pkg::FN_XOR:  regs[rd] = regs[rs] ^ regs[rt];
            mips_pkg::FN_SLT:  regs[rd] = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
            default: begin
            end
          endcase
        end
        mips_pkg::OP_J:     npc = {npc[31:28], instr[25:0], 2'b00};
        mips_pkg::OP_JAL: begin
          regs[31] = npc;
          npc = {npc[31:28], instr[25:0], 2'b00};
        end
        mips_pkg::OP_BEQ:   npc = (regs[rs] == regs[rt]) ? npc + (se << 2) : npc;
        mips_pkg::OP_BNE:   npc = (regs[rs] != regs[rt]) ? npc + (se << 2) : npc;
        mips_pkg::OP_ADDIU: regs[rt] = regs[rs] + se;
        mips_pkg::OP_SLTI:  regs[rt] = ($signed(regs[rs]) < $signed(se)) ? 32'd1 : 32'd0;
        mips_pkg::OP_ANDI:  regs[rt] = regs[rs] & {16'h0, instr[15:0]};
        mips_pkg::OP_ORI:   regs[rt] = regs[rs] | {16'h0, instr[15:0]};
        mips_pkg::OP_XORI:  regs[rt] = regs[rs] ^ {16'h0, instr[15:0]};
        mips_pkg::OP_LUI:   regs[rt] = {instr[15:0], 16'h0};
        mips_pkg::OP_LW:    regs[rt] = (eoff < 32'd1024) ? mem[eoff[9:2]] : 32'h0;
        mips_pkg::OP_SW: begin
          exp_addr.push_back(eoff + DATA_BASE);
          exp_data.push_back(regs[rt]);
          if (eoff < 32'd1024) begin
            mem[eoff[9:2]] = regs[rt];
          end
        end
        default: begin
        end
      endcase
      regs[0] = 32'h0;
      pc = npc;
      steps++;
    end
    exp_v0 = regs[2];
  endtask

  task automatic check_cycle();
    if (read_i && write_i) begin
      $display("read_o and write_o were high together at %0t", $time);
      errors++;
    end
    if (halted && (read_i || write_i)) begin
      $display("A bus strobe was raised after halt at %0t", $time);
      errors++;
    end
    if (held) begin
      if (!(read_i || write_i)) begin
        $display("The strobe was dropped while waitrequest was high at %0t", $time);
        errors++;
      end
      if (address_i != held_addr) begin
        $display("Error: address_o changed under waitrequest, was %h, now %h",
                 held_addr, address_i);
        errors++;
      end
      if (held_write && writedata_i != held_data) begin
        $display("Error: writedata_o changed under waitrequest, was %h, now %h",
                 held_data, writedata_i);
        errors++;
      end
    end
    if (first_read && read_i) begin
      first_read = 1'b0;
      if (address_i != mips_pkg::RESET_VECTOR) begin
        $display("Error: address_o of first read expected %h, got %h",
                 mips_pkg::RESET_VECTOR, address_i);
        errors++;
      end
    end
    if (write_i && !waitrequest_i) begin
      if (exp_addr.size() == 0) begin
        $display("The DUT wrote to %h but the model has no store left", address_i);
        errors++;
      end else begin
        if (address_i != exp_addr[0]) begin
          $display("Error: address_o expected %h, got %h", exp_addr[0], address_i);
          errors++;
        end
        if (writedata_i != byte_swap(exp_data[0])) begin
          $display("Error: writedata_o expected %h, got %h", byte_swap(exp_data[0]),
                   writedata_i);
          errors++;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
    if (!active_i && !halted) begin
      halted = 1'b1;
      if (register_v0_i != exp_v0) begin
        $display("Error: register_v0_o expected %h, got %h", exp_v0, register_v0_i);
        errors++;
      end
      if (exp_addr.size() != 0) begin
        $display("The DUT halted with %0d stores still missing", exp_addr.size());
        errors++;
      end
    end
    held = (read_i || write_i) && waitrequest_i;
    held_write = write_i;
    held_addr = address_i;
    held_data = writedata_i;
  endtask

  always @(posedge clk) begin
    if (start_i) begin
      run_model();
      halted = 1'b0;
      first_read = 1'b1;
    end
    if (reset) begin
      held = 1'b0;
      if (read_i || write_i) begin
        $display("A bus strobe was raised during reset at %0t", $time);
        errors++;
      end
    end else begin
      check_cycle();
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu_bus;

  localparam int SEED         = 13943;
  localparam int NUM_TESTS    = 8;
  localparam int MAX_INSTR    = 40;
  localparam int RESET_CYCLES = 16;
  localparam int PROG_WORDS   = 64;
  localparam int DATA_WORDS   = 256;
  localparam logic [31:0] DATA_BASE = 32'h0000_1000;
  // Five states plus two accesses of up to three wait cycles per instruction
  localparam int CYCLE_LIMIT =
    2 * (NUM_TESTS * MAX_INSTR * (5 + 2 * 3) + NUM_TESTS * RESET_CYCLES);

  localparam logic [5:0] R_FUNCS [8] = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU,
    mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_SLT,
    mips_pkg::FN_SLL, mips_pkg::FN_SRL};
  localparam logic [5:0] I_OPS [6] = '{mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
    mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI};

  logic        clk;
  logic        reset = 1'b1;
  logic        start = 1'b0;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] address;
  logic        write;
  logic        read;
  logic        waitrequest = 1'b0;
  logic [31:0] writedata;
  logic [31:0] readdata = 32'h0;
  logic [31:0] prog [PROG_WORDS];
  logic [31:0] dmem [DATA_WORDS];
  logic        in_access = 1'b0;
  int          wait_left = 0;
  int          cycles = 0;
  int          errors;

  mips_cpu_bus #(
    .REG_COUNT (32)
  ) i_dut (
    .clk           (clk),
    .reset         (reset),
    .active_o      (active),
    .register_v0_o (register_v0),
    .address_o     (address),
    .write_o       (write),
    .read_o        (read),
    .waitrequest_i (waitrequest),
    .writedata_o   (writedata),
    .readdata_i    (readdata)
  );

  mips_checker i_checker (
    .clk           (clk),
    .reset         (reset),
    .start_i       (start),
    .prog_i        (prog),
    .dmem_i        (dmem),
    .active_i      (active),
    .register_v0_i (register_v0),
    .address_i     (address),
    .write_i       (write),
    .read_i        (read),
    .waitrequest_i (waitrequest),
    .writedata_i   (writedata),
    .errors_o      (errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] swap_lanes(logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic [31:0] fill_word(logic [31:0] addr, int test);
    return (addr * 32'h9E37_79B1) ^ (32'(test) << 24) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic [31:0] enc_r(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd, logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, funct};
  endfunction

  function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] enc_j(logic [5:0] op, int idx);
    logic [31:0] addr;
    addr = mips_pkg::RESET_VECTOR + 32'(idx * 4);
    return {op, addr[27:2]};
  endfunction

  // r28 is the data base and r31 the link, so random ops stay in r1..r15
  function automatic logic [4:0] pick_dest();
    return 5'(1 + $urandom % 15);
  endfunction

  function automatic logic [4:0] pick_source();
    return 5'($urandom % 16);
  endfunction

  task automatic build_program(output int n);
    int          kind;
    int          target;
    logic [5:0]  funct;
    logic [5:0]  op;
    logic [15:0] offset;
    n = 30 + int'($urandom % 11);
    prog = '{default: 32'h0};
    prog[0] = enc_i(mips_pkg::OP_ORI, 5'd0, 5'd28, DATA_BASE[15:0]);
    for (int k = 1; k <= 4; k++) begin
      prog[6'(k)] = enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'(k), 16'($urandom));
    end
    for (int i = 5; i < n - 2; i++) begin
      kind = int'($urandom % 20);
      // Forward targets only, never past the final ADDU
      target = i + 1 + int'($urandom % 32'(n - 2 - i));
      offset = 16'(($urandom % 16) * 4);
      if (kind < 6) begin
        funct = R_FUNCS[3'($urandom)];
        prog[6'(i)] = enc_r(funct, pick_source(), pick_source(), pick_dest(),
                            (funct == mips_pkg::FN_SLL || funct == mips_pkg::FN_SRL) ?
                            5'($urandom) : 5'd0);
      end else if (kind < 11) begin
        op = I_OPS[3'($urandom % 6)];
        prog[6'(i)] = enc_i(op, pick_source(), pick_dest(), 16'($urandom));
      end else if (kind < 13) begin
        prog[6'(i)] = enc_i(mips_pkg::OP_LW, 5'd28, pick_dest(), offset);
      end else if (kind < 16) begin
        prog[6'(i)] = enc_i(mips_pkg::OP_SW, 5'd28,
                            ($urandom % 4 == 0) ? 5'd31 : pick_source(), offset);
      end else if (kind < 18) begin
        op = (kind == 16) ? mips_pkg::OP_BEQ : mips_pkg::OP_BNE;
        prog[6'(i)] = enc_i(op, pick_source(), pick_source(), 16'(target - i - 1));
      end else begin
        op = (kind == 18) ? mips_pkg::OP_J : mips_pkg::OP_JAL;
        prog[6'(i)] = enc_j(op, target);
      end
    end
    prog[6'(n - 2)] = enc_r(mips_pkg::FN_ADDU, pick_source(), pick_source(), 5'd2, 5'd0);
    prog[6'(n - 1)] = enc_r(mips_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0);
  endtask

  task automatic complete_access();
    logic [31:0] ioff;
    logic [31:0] doff;
    ioff = address - mips_pkg::RESET_VECTOR;
    doff = address - DATA_BASE;
    if (read) begin
      if (ioff < 32'(PROG_WORDS * 4)) begin
        readdata = swap_lanes(prog[ioff[7:2]]);
      end else if (doff < 32'(DATA_WORDS * 4)) begin
        readdata = swap_lanes(dmem[doff[9:2]]);
      end else begin
        readdata = 32'h0;
      end
    end
    if (write && doff < 32'(DATA_WORDS * 4)) begin
      dmem[doff[9:2]] = swap_lanes(writedata);
    end
  endtask

  // Slave side with 0 to 3 wait cycles per transfer
  always @(negedge clk) begin
    if (!(read || write)) begin
      in_access = 1'b0;
      waitrequest = 1'b0;
    end else begin
      if (!in_access) begin
        in_access = 1'b1;
        wait_left = int'($urandom % 4);
      end
      if (wait_left > 0) begin
        waitrequest = 1'b1;
        wait_left--;
      end else begin
        waitrequest = 1'b0;
        in_access = 1'b0;
        complete_access();
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the DUT did not halt within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    int errors_before;
    int failed;
    int n_instr;
    failed = 0;
    void'($urandom(SEED));
    for (int test = 0; test < NUM_TESTS; test++) begin
      build_program(n_instr);
      for (int k = 0; k < DATA_WORDS; k++) begin
        dmem[8'(k)] = fill_word(DATA_BASE + 32'(k * 4), test);
      end
      errors_before = errors;
      @(negedge clk);
      reset = 1'b1;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      repeat (RESET_CYCLES - 1) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      while (active) @(negedge clk);
      // A few idle cycles to catch strobes after halt
      repeat (4) @(negedge clk);
      if (errors == errors_before) begin
        $display("test %0d: %0d instructions, passed", test, n_instr);
      end else begin
        $display("test %0d: %0d instructions, FAILED with %0d errors", test, n_instr,
                 errors - errors_before);
        failed++;
      end
    end
    $display("%0d tests run, %0d passed, %0d failed", NUM_TESTS, NUM_TESTS - failed, failed);
    if (failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hw/mips_pkg.sv
hw/mips_instr_if.sv
hw/mips_fsm.sv
hw/mips_ir.sv
hw/mips_control.sv
hw/mips_pc_unit.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_cpu_bus.sv
sim/mips_checker.sv
sim/tb_mips_cpu_bus.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_mips_cpu_bus \
    -Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
